// File: Bender.yml
package:
  name: reorder_buffer

sources:
  - logic/rob_pkg.sv
  - logic/rob_payload.sv
  - logic/rob_status.sv
  - logic/rob_commit.sv
  - logic/reorder_buffer.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/reorder_buffer_tb.sv

// File: logic/reorder_buffer.sv
module reorder_buffer (
    input  logic                          clk,
    input  logic                          rst,

    // dispatch
    input  logic                          dispatch,
    input  rob_pkg::inst_kind_e           disp_kind          [rob_pkg::disp_w],
    input  logic [rob_pkg::reg_w-1:0]     disp_dest          [rob_pkg::disp_w],
    input  logic                          disp_predict_taken [rob_pkg::disp_w],
    output logic                          rob_full,
    output logic [rob_pkg::rob_id_w-1:0]  rob_id_next        [rob_pkg::disp_w],

    // common data bus
    input  logic                          cdb_valid          [rob_pkg::disp_w],
    input  logic [rob_pkg::rob_id_w-1:0]  cdb_rob_id         [rob_pkg::disp_w],
    input  logic [rob_pkg::xlen-1:0]      cdb_value          [rob_pkg::disp_w],
    input  logic                          cdb_taken          [rob_pkg::disp_w],

    // commit
    output logic                          commit_valid       [rob_pkg::disp_w],
    output logic [rob_pkg::reg_w-1:0]     commit_dest        [rob_pkg::disp_w],
    output logic [rob_pkg::xlen-1:0]      commit_value       [rob_pkg::disp_w],
    output logic [rob_pkg::order_w-1:0]   commit_order       [rob_pkg::disp_w],
    output logic                          flush
);

    logic [rob_pkg::rob_id_w-1:0]  head;
    logic [rob_pkg::rob_id_w-1:0]  alloc_id;
    logic                          empty;
    logic                          pop;

    rob_pkg::inst_kind_e           head_kind    [rob_pkg::disp_w];
    logic [rob_pkg::reg_w-1:0]     head_dest    [rob_pkg::disp_w];
    logic                          head_predict [rob_pkg::disp_w];
    logic                          head_done    [rob_pkg::disp_w];
    logic [rob_pkg::xlen-1:0]      head_value   [rob_pkg::disp_w];
    logic                          head_taken   [rob_pkg::disp_w];

    // next dispatch lands at the tail and the slot after it
    always_comb begin
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            rob_id_next[i] = alloc_id + rob_pkg::rob_id_w'(i);
        end
    end

    rob_payload u_payload (
        .clk, .rst, .dispatch, .disp_kind, .disp_dest, .disp_predict_taken,
        .pop, .flush, .head_kind, .head_dest, .head_predict,
        .head, .alloc_id, .empty, .rob_full
    );

    // every dispatch allocates, flush takes priority inside the table
    rob_status u_status (
        .clk, .rst, .alloc(dispatch), .alloc_id, .head, .flush,
        .cdb_valid, .cdb_rob_id, .cdb_value, .cdb_taken,
        .head_done, .head_value, .head_taken
    );

    rob_commit u_commit (
        .clk, .rst, .empty, .head_kind, .head_dest, .head_predict,
        .head_done, .head_value, .head_taken, .pop, .flush,
        .commit_valid, .commit_dest, .commit_value, .commit_order
    );

endmodule

// File: logic/rob_commit.sv
module rob_commit (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          empty,

    // head payload
    input  rob_pkg::inst_kind_e           head_kind    [rob_pkg::disp_w],
    input  logic [rob_pkg::reg_w-1:0]     head_dest    [rob_pkg::disp_w],
    input  logic                          head_predict [rob_pkg::disp_w],

    // head completion status
    input  logic                          head_done    [rob_pkg::disp_w],
    input  logic [rob_pkg::xlen-1:0]      head_value   [rob_pkg::disp_w],
    input  logic                          head_taken   [rob_pkg::disp_w],

    output logic                          pop,
    output logic                          flush,

    output logic                          commit_valid [rob_pkg::disp_w],
    output logic [rob_pkg::reg_w-1:0]     commit_dest  [rob_pkg::disp_w],
    output logic [rob_pkg::xlen-1:0]      commit_value [rob_pkg::disp_w],
    output logic [rob_pkg::order_w-1:0]   commit_order [rob_pkg::disp_w]
);

    logic                          mispredict [rob_pkg::disp_w];
    logic                          all_done;
    logic [rob_pkg::order_w-1:0]   order_cnt;

    // a branch went the wrong way if the outcome disagrees with the prediction
    always_comb begin
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            mispredict[i] = (head_kind[i] == rob_pkg::kind_branch) &&
                            (head_taken[i] != head_predict[i]);
        end
    end

    // retirement is all or nothing for the pair
    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            all_done = all_done && head_done[i];
        end
    end

    assign pop   = !empty && all_done;
    assign flush = pop && (mispredict[0] || mispredict[1]);

    // the younger slot is on the wrong path if slot 0 mispredicted
    assign commit_valid[0] = pop;
    assign commit_valid[1] = pop && !mispredict[0];

    always_comb begin
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            commit_dest[i]  = head_dest[i];
            // for a branch this is the redirect pc
            commit_value[i] = head_value[i];
            commit_order[i] = order_cnt + rob_pkg::order_w'(i);
        end
    end

    // advance by however many instructions actually retired
    always_ff @(posedge clk) begin
        if (rst) begin
            order_cnt <= '0;
        end else if (pop) begin
            if (commit_valid[1]) begin
                order_cnt <= order_cnt + rob_pkg::order_w'(2);
            end else begin
                order_cnt <= order_cnt + rob_pkg::order_w'(1);
            end
        end
    end

    // a flush leaves the buffer empty at the next edge
    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |=> empty);

endmodule

// File: logic/rob_payload.sv
module rob_payload (
    input  logic                          clk,
    input  logic                          rst,

    // dispatch side with two lanes taken together
    input  logic                          dispatch,
    input  rob_pkg::inst_kind_e           disp_kind          [rob_pkg::disp_w],
    input  logic [rob_pkg::reg_w-1:0]     disp_dest          [rob_pkg::disp_w],
    input  logic                          disp_predict_taken [rob_pkg::disp_w],

    // retirement control from the commit block
    input  logic                          pop,
    input  logic                          flush,

    // the two eldest entries
    output rob_pkg::inst_kind_e           head_kind          [rob_pkg::disp_w],
    output logic [rob_pkg::reg_w-1:0]     head_dest          [rob_pkg::disp_w],
    output logic                          head_predict       [rob_pkg::disp_w],

    output logic [rob_pkg::rob_id_w-1:0]  head,
    output logic [rob_pkg::rob_id_w-1:0]  alloc_id,
    output logic                          empty,
    output logic                          rob_full
);

    rob_pkg::inst_kind_e           kind_mem    [rob_pkg::rob_depth];
    logic [rob_pkg::reg_w-1:0]     dest_mem    [rob_pkg::rob_depth];
    logic                          predict_mem [rob_pkg::rob_depth];

    logic [rob_pkg::rob_id_w-1:0]  tail;
    // one bit wider than the id so a completely full buffer is representable
    logic [rob_pkg::rob_id_w:0]    count;

    // payload write at the tail
    // a dispatch in a flush cycle is dropped
    always_ff @(posedge clk) begin
        if (dispatch && !flush) begin
            for (int i = 0; i < rob_pkg::disp_w; i++) begin
                kind_mem[tail + rob_pkg::rob_id_w'(i)]    <= disp_kind[i];
                dest_mem[tail + rob_pkg::rob_id_w'(i)]    <= disp_dest[i];
                predict_mem[tail + rob_pkg::rob_id_w'(i)] <= disp_predict_taken[i];
            end
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (dispatch) begin
                tail <= tail + rob_pkg::rob_id_w'(rob_pkg::disp_w);
            end
            if (pop) begin
                head <= head + rob_pkg::rob_id_w'(rob_pkg::disp_w);
            end
            case ({dispatch, pop})
                2'b10:   count <= count + (rob_pkg::rob_id_w + 1)'(rob_pkg::disp_w);
                2'b01:   count <= count - (rob_pkg::rob_id_w + 1)'(rob_pkg::disp_w);
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            head_kind[i]    = kind_mem[head + rob_pkg::rob_id_w'(i)];
            head_dest[i]    = dest_mem[head + rob_pkg::rob_id_w'(i)];
            head_predict[i] = predict_mem[head + rob_pkg::rob_id_w'(i)];
        end
    end

    assign alloc_id = tail;
    assign empty    = (count == '0);
    // full as soon as a whole dispatch group no longer fits
    assign rob_full = (count > (rob_pkg::rob_id_w + 1)'(rob_pkg::rob_depth - rob_pkg::disp_w));

    // the front end must hold off while full
    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        !(dispatch && rob_full));

    // commit only retires what was dispatched
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        !(pop && empty));

endmodule

// File: logic/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int rob_depth = 8;
    localparam int rob_id_w = 3;

    // instructions per dispatch, per commit, and number of result bus ports
    localparam int disp_w = 2;

    // datapath widths
    localparam int xlen = 32;
    localparam int reg_w = 5;

    // running retirement count, wide enough to never wrap in practice
    localparam int order_w = 64;

    // what the commit stage needs to know about an entry
    // branches carry a redirect pc in the value field and may mispredict
    typedef enum logic [1:0] {
        kind_alu    = 2'd0,
        kind_branch = 2'd1
    } inst_kind_e;

endpackage

// File: logic/rob_status.sv
module rob_status (
    input  logic                          clk,
    input  logic                          rst,

    // new slots handed out at the tail
    input  logic                          alloc,
    input  logic [rob_pkg::rob_id_w-1:0]  alloc_id,

    input  logic [rob_pkg::rob_id_w-1:0]  head,
    input  logic                          flush,

    // result bus ports
    input  logic                          cdb_valid  [rob_pkg::disp_w],
    input  logic [rob_pkg::rob_id_w-1:0]  cdb_rob_id [rob_pkg::disp_w],
    input  logic [rob_pkg::xlen-1:0]      cdb_value  [rob_pkg::disp_w],
    input  logic                          cdb_taken  [rob_pkg::disp_w],

    // completion state of the two eldest slots
    output logic                          head_done  [rob_pkg::disp_w],
    output logic [rob_pkg::xlen-1:0]      head_value [rob_pkg::disp_w],
    output logic                          head_taken [rob_pkg::disp_w]
);

    logic [rob_pkg::rob_depth-1:0]  done;
    logic [rob_pkg::xlen-1:0]       value_mem [rob_pkg::rob_depth];
    logic                           taken_mem [rob_pkg::rob_depth];

    // done bits: cleared for freshly allocated slots, set by the bus
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            done <= '0;
        end else begin
            if (alloc) begin
                for (int i = 0; i < rob_pkg::disp_w; i++) begin
                    done[alloc_id + rob_pkg::rob_id_w'(i)] <= 1'b0;
                end
            end
            for (int p = 0; p < rob_pkg::disp_w; p++) begin
                if (cdb_valid[p]) begin
                    done[cdb_rob_id[p]] <= 1'b1;
                end
            end
        end
    end

    // result payload, only meaningful once the matching done bit is set
    always_ff @(posedge clk) begin
        for (int p = 0; p < rob_pkg::disp_w; p++) begin
            if (cdb_valid[p]) begin
                value_mem[cdb_rob_id[p]] <= cdb_value[p];
                taken_mem[cdb_rob_id[p]] <= cdb_taken[p];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            head_done[i]  = done[head + rob_pkg::rob_id_w'(i)];
            head_value[i] = value_mem[head + rob_pkg::rob_id_w'(i)];
            head_taken[i] = taken_mem[head + rob_pkg::rob_id_w'(i)];
        end
    end

    // execution units never broadcast the same id twice in one cycle
    a_ports_distinct: assert property (@(posedge clk) disable iff (rst)
        (cdb_valid[0] && cdb_valid[1]) |-> (cdb_rob_id[0] != cdb_rob_id[1]));

    // every slot completes exactly once per allocation
    for (genvar p = 0; p < rob_pkg::disp_w; p++) begin : g_port_chk
        a_single_complete: assert property (@(posedge clk) disable iff (rst || flush)
            cdb_valid[p] |-> !done[cdb_rob_id[p]]);
    end

endmodule

// File: reorder_buffer.f
+incdir+tests
logic/rob_pkg.sv
logic/rob_payload.sv
logic/rob_status.sv
logic/rob_commit.sv
logic/reorder_buffer.sv
tests/reorder_buffer_tb.sv

// File: tests/rob_model.svh
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// mirror of the slot array, pointers and retirement count
rob_pkg::inst_kind_e        m_kind  [rob_pkg::rob_depth];
bit [rob_pkg::reg_w-1:0]    m_dest  [rob_pkg::rob_depth];
bit                         m_pred  [rob_pkg::rob_depth];
bit                         m_done  [rob_pkg::rob_depth];
bit [rob_pkg::xlen-1:0]     m_value [rob_pkg::rob_depth];
bit                         m_taken [rob_pkg::rob_depth];
int                         m_head;
int                         m_tail;
int                         m_count;
bit [rob_pkg::order_w-1:0]  m_order;

// predicted commit outputs for the current cycle
bit                         exp_pop;
bit                         exp_flush;
bit                         exp_valid [rob_pkg::disp_w];
bit [rob_pkg::reg_w-1:0]    exp_dest  [rob_pkg::disp_w];
bit [rob_pkg::xlen-1:0]     exp_value [rob_pkg::disp_w];
bit [rob_pkg::order_w-1:0]  exp_order [rob_pkg::disp_w];

function automatic void model_reset();
    for (int s = 0; s < rob_pkg::rob_depth; s++) begin
        m_kind[s]  = rob_pkg::kind_alu;
        m_dest[s]  = '0;
        m_pred[s]  = 1'b0;
        m_done[s]  = 1'b0;
        m_value[s] = '0;
        m_taken[s] = 1'b0;
    end
    m_head  = 0;
    m_tail  = 0;
    m_count = 0;
    m_order = '0;
endfunction

// commit decision from the two eldest slots
function automatic void model_eval();
    bit mis [rob_pkg::disp_w];
    bit all_done;
    int slot;
    all_done = 1'b1;
    for (int i = 0; i < rob_pkg::disp_w; i++) begin
        slot = (m_head + i) % rob_pkg::rob_depth;
        mis[i] = (m_kind[slot] == rob_pkg::kind_branch) && (m_taken[slot] != m_pred[slot]);
        all_done = all_done && m_done[slot];
        exp_dest[i]  = m_dest[slot];
        exp_value[i] = m_value[slot];
        exp_order[i] = m_order + rob_pkg::order_w'(i);
    end
    exp_pop      = (m_count != 0) && all_done;
    exp_flush    = exp_pop && (mis[0] || mis[1]);
    exp_valid[0] = exp_pop;
    exp_valid[1] = exp_pop && !mis[0];
endfunction

function automatic void model_complete(int id, bit [rob_pkg::xlen-1:0] value, bit taken);
    m_done[id]  = 1'b1;
    m_value[id] = value;
    m_taken[id] = taken;
endfunction

function automatic void model_allocate(int lane, rob_pkg::inst_kind_e kind,
                                       bit [rob_pkg::reg_w-1:0] dest, bit pred);
    int slot;
    slot = (m_tail + lane) % rob_pkg::rob_depth;
    m_kind[slot] = kind;
    m_dest[slot] = dest;
    m_pred[slot] = pred;
    m_done[slot] = 1'b0;
endfunction

// pointer and counter update at the edge, using the decision made before it
function automatic void model_commit_edge(bit disp);
    if (exp_valid[1]) begin
        m_order = m_order + rob_pkg::order_w'(2);
    end else if (exp_valid[0]) begin
        m_order = m_order + rob_pkg::order_w'(1);
    end
    if (exp_flush) begin
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
        for (int s = 0; s < rob_pkg::rob_depth; s++) begin
            m_done[s] = 1'b0;
        end
    end else begin
        if (disp) begin
            m_tail  = (m_tail + rob_pkg::disp_w) % rob_pkg::rob_depth;
            m_count = m_count + rob_pkg::disp_w;
        end
        if (exp_pop) begin
            m_head  = (m_head + rob_pkg::disp_w) % rob_pkg::rob_depth;
            m_count = m_count - rob_pkg::disp_w;
        end
    end
endfunction

function automatic bit model_full();
    return m_count > (rob_pkg::rob_depth - rob_pkg::disp_w);
endfunction

function automatic int model_next_id(int lane);
    return (m_tail + lane) % rob_pkg::rob_depth;
endfunction

`endif

// File: tests/reorder_buffer_tb.sv
module reorder_buffer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int stim_cycles    = 2000;
    localparam int timeout_cycles = 2 * stim_cycles;

    logic                          clk;
    logic                          rst;
    logic                          dispatch;
    rob_pkg::inst_kind_e           disp_kind          [rob_pkg::disp_w];
    logic [rob_pkg::reg_w-1:0]     disp_dest          [rob_pkg::disp_w];
    logic                          disp_predict_taken [rob_pkg::disp_w];
    logic                          rob_full;
    logic [rob_pkg::rob_id_w-1:0]  rob_id_next        [rob_pkg::disp_w];
    logic                          cdb_valid          [rob_pkg::disp_w];
    logic [rob_pkg::rob_id_w-1:0]  cdb_rob_id         [rob_pkg::disp_w];
    logic [rob_pkg::xlen-1:0]      cdb_value          [rob_pkg::disp_w];
    logic                          cdb_taken          [rob_pkg::disp_w];
    logic                          commit_valid       [rob_pkg::disp_w];
    logic [rob_pkg::reg_w-1:0]     commit_dest        [rob_pkg::disp_w];
    logic [rob_pkg::xlen-1:0]      commit_value       [rob_pkg::disp_w];
    logic [rob_pkg::order_w-1:0]   commit_order       [rob_pkg::disp_w];
    logic                          flush;

    logic [31:0]  lfsr_state;
    bit           checking;
    int           cycle_count;

    `include "rob_model.svh"

    reorder_buffer uut (
        .clk, .rst, .dispatch, .disp_kind, .disp_dest, .disp_predict_taken,
        .rob_full, .rob_id_next, .cdb_valid, .cdb_rob_id, .cdb_value, .cdb_taken,
        .commit_valid, .commit_dest, .commit_value, .commit_order, .flush
    );

    always #5 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic bit lfsr_step();
        bit fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // apply what the DUT samples at this edge, then predict the next cycle
    task automatic follow_edge();
        if (!exp_flush) begin
            for (int p = 0; p < rob_pkg::disp_w; p++) begin
                if (cdb_valid[p]) begin
                    model_complete(int'(cdb_rob_id[p]), cdb_value[p], cdb_taken[p]);
                end
            end
            if (dispatch) begin
                for (int i = 0; i < rob_pkg::disp_w; i++) begin
                    model_allocate(i, disp_kind[i], disp_dest[i], disp_predict_taken[i]);
                end
            end
        end
        model_commit_edge(dispatch);
        model_eval();
    endtask

    task automatic drive_inputs(input bit allow_dispatch);
        int pending[$];
        int pick;
        int id;
        int slot;
        for (int k = 0; k < m_count; k++) begin
            slot = (m_head + k) % rob_pkg::rob_depth;
            if (!m_done[slot]) begin
                pending.push_back(slot);
            end
        end
        if (allow_dispatch && !model_full() && rand_bits(1) == 1) begin
            dispatch <= 1'b1;
            for (int i = 0; i < rob_pkg::disp_w; i++) begin
                if (rand_bits(1) == 1) begin
                    disp_kind[i] <= rob_pkg::kind_branch;
                end else begin
                    disp_kind[i] <= rob_pkg::kind_alu;
                end
                disp_dest[i]          <= rob_pkg::reg_w'(rand_bits(rob_pkg::reg_w));
                disp_predict_taken[i] <= 1'(rand_bits(1));
            end
        end else begin
            dispatch <= 1'b0;
        end
        // distinct outstanding ids in no particular order
        for (int p = 0; p < rob_pkg::disp_w; p++) begin
            if (pending.size() > 0 && rand_bits(1) == 1) begin
                pick = int'(rand_bits(3)) % pending.size();
                id = pending[pick];
                pending.delete(pick);
                cdb_valid[p]  <= 1'b1;
                cdb_rob_id[p] <= rob_pkg::rob_id_w'(id);
                cdb_value[p]  <= rand_bits(rob_pkg::xlen);
                // branches resolve as predicted seven times out of eight
                if (m_kind[id] == rob_pkg::kind_branch) begin
                    cdb_taken[p] <= m_pred[id] ^ (rand_bits(3) == 0);
                end else begin
                    cdb_taken[p] <= 1'(rand_bits(1));
                end
            end else begin
                cdb_valid[p] <= 1'b0;
            end
        end
    endtask

    task automatic check_outputs();
        compare_value("rob_full", 64'(rob_full), 64'(model_full()));
        compare_value("flush", 64'(flush), 64'(exp_flush));
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            compare_value($sformatf("rob_id_next[%0d]", i), 64'(rob_id_next[i]),
                          64'(model_next_id(i)));
            compare_value($sformatf("commit_valid[%0d]", i), 64'(commit_valid[i]),
                          64'(exp_valid[i]));
            if (exp_valid[i]) begin
                compare_value($sformatf("commit_dest[%0d]", i), 64'(commit_dest[i]),
                              64'(exp_dest[i]));
                compare_value($sformatf("commit_value[%0d]", i), 64'(commit_value[i]),
                              64'(exp_value[i]));
                compare_value($sformatf("commit_order[%0d]", i), commit_order[i],
                              exp_order[i]);
            end
        end
    endtask

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (checking) begin
            check_outputs();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("the run hung: buffer not drained after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        dispatch   = 1'b0;
        for (int i = 0; i < rob_pkg::disp_w; i++) begin
            disp_kind[i]          = rob_pkg::kind_alu;
            disp_dest[i]          = '0;
            disp_predict_taken[i] = 1'b0;
            cdb_valid[i]          = 1'b0;
            cdb_rob_id[i]         = '0;
            cdb_value[i]          = '0;
            cdb_taken[i]          = 1'b0;
        end
        lfsr_state  = 32'hc940;
        checking    = 1'b0;
        cycle_count = 0;
        model_reset();
        model_eval();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;
        for (int c = 0; c < stim_cycles; c++) begin
            @(posedge clk);
            follow_edge();
            drive_inputs(1'b1);
        end
        // no more dispatch so keep completing until everything retired
        do begin
            @(posedge clk);
            follow_edge();
            drive_inputs(1'b0);
        end while (m_count != 0);
        @(negedge clk);
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule
